//--- logic/ecc_pkg.sv
/*
  ecc_pkg
  widths and types of the 32+8 single-error-correcting code. also holds the
  nibble-pair table that ties every nibble to two syndrome bits, shared by
  the syndrome trees and the error locator.
*/
`default_nettype none

package ecc_pkg;

  localparam int DATA_W   = 32;                 // data bits per word.
  localparam int CHECK_W  = 8;                  // check and syndrome bits.
  localparam int NIBBLE_W = 4;                  // bits per nibble group.
  localparam int HALF_W   = DATA_W / 2;         // data bits per half word.
  localparam int HALF_NIB = HALF_W / NIBBLE_W;  // nibbles per half word.
  localparam int SYN_HALF = CHECK_W / 2;        // syndrome bits per half.

  // pair pattern per nibble, indexed by nibble number within its half.
  // low-half nibbles hit syndrome bits 7..4, high-half nibbles hit 3..0.
  localparam logic [HALF_NIB-1:0][SYN_HALF-1:0] PAIR_PAT = {
    4'b1010,  // nibble 3 and 7.
    4'b0110,  // nibble 2 and 6.
    4'b1001,  // nibble 1 and 5.
    4'b0101   // nibble 0 and 4.
  };

  typedef logic [DATA_W-1:0]  data_t;
  typedef logic [CHECK_W-1:0] check_t;
  typedef logic [CHECK_W-1:0] syndrome_t;

  // decoder outcome, located sits in the lsb.
  typedef struct packed {
    logic unlocated;  // nonzero syndrome that points to no data bit.
    logic located;    // one data bit was flipped back.
  } ecc_status_t;

endpackage

`default_nettype wire

//--- logic/apb_pkg.sv
/*
  apb_pkg
  bus widths, register map and field positions of the sec peripheral.
*/
`default_nettype none

package apb_pkg;

  localparam int APB_ADDR_W = 4;   // byte address within the block.
  localparam int APB_DATA_W = 32;

  typedef logic [APB_ADDR_W-1:0] reg_addr_t;

  // register offsets.
  localparam reg_addr_t REG_DATA   = 4'h0;  // data word, read/write.
  localparam reg_addr_t REG_CHECK  = 4'h4;  // check bits and enable.
  localparam reg_addr_t REG_CORR   = 4'h8;  // corrected word, read-only.
  localparam reg_addr_t REG_STATUS = 4'hC;  // syndrome and flags, read-only.

  // enable flag position in REG_CHECK, check bits sit below it.
  localparam int CHECK_EN_BIT = 8;

endpackage

`default_nettype wire

//--- logic/ecc_if.sv
/*
  ecc_if
  carries the codeword from the register block to the decoder, and the
  syndrome, corrected word and status back again.
*/
`timescale 1ns/1ps
`default_nettype none

interface ecc_if;

  ecc_pkg::data_t      data;       // stored data word.
  ecc_pkg::check_t     check;      // stored check bits.
  logic                check_en;   // check bits take part when set.
  ecc_pkg::syndrome_t  syndrome;
  ecc_pkg::data_t      corrected;
  ecc_pkg::ecc_status_t status;

  // register block side.
  modport regs (
    output data, check, check_en,
    input  corrected, syndrome, status
  );

  // syndrome trees.
  modport syn (
    input  data, check, check_en,
    output syndrome
  );

  // locator and correction.
  modport loc (
    input  data, syndrome,
    output corrected, status
  );

endinterface

`default_nettype wire

//--- logic/sec_regs.sv
/*
  sec_regs
  apb slave of the sec peripheral. holds the data word, check bits and
  check enable, and returns them or the decoder results on reads.
  no wait states. unmapped offsets and writes to read-only registers
  answer with pslverr and change nothing.
*/
`timescale 1ns/1ps
`default_nettype none

module sec_regs (
  input  logic                             pclk,
  input  logic                             rst_n,
  input  logic                             psel,
  input  logic                             penable,
  input  logic                             pwrite,
  input  apb_pkg::reg_addr_t               paddr,
  input  logic [apb_pkg::APB_DATA_W-1:0]   pwdata,
  output logic [apb_pkg::APB_DATA_W-1:0]   prdata,
  output logic                             pready,
  output logic                             pslverr,
  ecc_if.regs                              ecc
);

  logic                           access;     // access phase.
  logic                           mapped;
  logic                           read_only;
  logic                           wr_en;
  logic [apb_pkg::APB_DATA_W-1:0] rd_mux;
  ecc_pkg::data_t                 data_q;
  ecc_pkg::check_t                check_q;
  logic                           check_en_q;

  assign access = psel & penable;

  // address decode and read-back mux.
  always_comb begin
    mapped    = 1'b1;
    read_only = 1'b0;
    rd_mux    = '0;
    case (paddr)
      apb_pkg::REG_DATA: begin
        rd_mux = data_q;
      end
      apb_pkg::REG_CHECK: begin
        rd_mux[ecc_pkg::CHECK_W-1:0]  = check_q;
        rd_mux[apb_pkg::CHECK_EN_BIT] = check_en_q;
      end
      apb_pkg::REG_CORR: begin
        read_only = 1'b1;
        rd_mux    = ecc.corrected;  // decoded from the current registers.
      end
      apb_pkg::REG_STATUS: begin
        read_only = 1'b1;
        rd_mux[ecc_pkg::CHECK_W-1:0] = ecc.syndrome;
        rd_mux[ecc_pkg::CHECK_W +: $bits(ecc_pkg::ecc_status_t)] = ecc.status;
      end
      default: begin
        mapped = 1'b0;
      end
    endcase
  end

  assign wr_en   = access & pwrite & mapped & ~read_only;
  assign pready  = 1'b1;  // never stretches an access.
  assign pslverr = access & (~mapped | (pwrite & read_only));
  assign prdata  = (access & ~pwrite) ? rd_mux : '0;

  // writes land on the edge that closes the access phase.
  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      data_q     <= '0;
      check_q    <= '0;
      check_en_q <= 1'b0;
    end else if (wr_en) begin
      if (paddr == apb_pkg::REG_DATA) begin
        data_q <= pwdata;
      end
      if (paddr == apb_pkg::REG_CHECK) begin
        check_q    <= pwdata[ecc_pkg::CHECK_W-1:0];
        check_en_q <= pwdata[apb_pkg::CHECK_EN_BIT];
      end
    end
  end

  // codeword to the decoder.
  assign ecc.data     = data_q;
  assign ecc.check    = check_q;
  assign ecc.check_en = check_en_q;

endmodule

`default_nettype wire

//--- logic/syndrome_gen.sv
/*
  syndrome_gen
  staged parity trees of the sec code. each nibble reduces to one parity
  bit, the nibble parities fold along the pair table, and the position
  parities of each half are added in. check bits join only when enabled.
*/
`timescale 1ns/1ps
`default_nettype none

module syndrome_gen (
  ecc_if.syn ecc
);

  logic [2*ecc_pkg::HALF_NIB-1:0] nib_par;  // one parity bit per nibble.
  logic [ecc_pkg::SYN_HALF-1:0]   pos_lo;   // bit-position parity, low half.
  logic [ecc_pkg::SYN_HALF-1:0]   pos_hi;   // bit-position parity, high half.
  logic [ecc_pkg::SYN_HALF-1:0]   pair_lo;  // low-half nibbles folded by pair.
  logic [ecc_pkg::SYN_HALF-1:0]   pair_hi;  // high-half nibbles folded by pair.
  ecc_pkg::check_t                check_gated;

  // first stage, nibble parity.
  always_comb begin
    for (int n = 0; n < 2*ecc_pkg::HALF_NIB; n++) begin
      nib_par[n] = ^ecc.data[n*ecc_pkg::NIBBLE_W +: ecc_pkg::NIBBLE_W];
    end
  end

  // position parity, one tree per bit position and half.
  always_comb begin
    pos_lo = '0;
    pos_hi = '0;
    for (int p = 0; p < ecc_pkg::NIBBLE_W; p++) begin
      for (int n = 0; n < ecc_pkg::HALF_NIB; n++) begin
        pos_lo[p] = pos_lo[p] ^ ecc.data[n*ecc_pkg::NIBBLE_W + p];
        pos_hi[p] = pos_hi[p] ^ ecc.data[ecc_pkg::HALF_W + n*ecc_pkg::NIBBLE_W + p];
      end
    end
  end

  // a nibble feeds the two syndrome bits set in its pair pattern.
  always_comb begin
    pair_lo = '0;
    pair_hi = '0;
    for (int j = 0; j < ecc_pkg::SYN_HALF; j++) begin
      for (int n = 0; n < ecc_pkg::HALF_NIB; n++) begin
        pair_lo[j] = pair_lo[j] ^ (nib_par[n] & ecc_pkg::PAIR_PAT[n][j]);
        pair_hi[j] = pair_hi[j] ^ (nib_par[ecc_pkg::HALF_NIB + n] & ecc_pkg::PAIR_PAT[n][j]);
      end
    end
  end

  assign check_gated = ecc.check & {ecc_pkg::CHECK_W{ecc.check_en}};

  // low half positions meet high half pairs and the other way round.
  assign ecc.syndrome = {pos_hi ^ pair_lo, pos_lo ^ pair_hi} ^ check_gated;

endmodule

`default_nettype wire

//--- logic/error_locator.sv
/*
  error_locator
  turns the syndrome into a flip mask and corrects the data word.
  a data bit is hit when one syndrome half is one-hot at its position and
  the other half matches its nibble-pair pattern. anything else nonzero
  is reported as unlocated and leaves the data as it is.
*/
`timescale 1ns/1ps
`default_nettype none

module error_locator (
  ecc_if.loc ecc
);

  logic [ecc_pkg::SYN_HALF-1:0] syn_lo;
  logic [ecc_pkg::SYN_HALF-1:0] syn_hi;
  logic                         lo_onehot;
  logic                         hi_onehot;
  logic [ecc_pkg::NIBBLE_W-1:0] pos_hit_lo;   // position of an error in low half.
  logic [ecc_pkg::NIBBLE_W-1:0] pos_hit_hi;   // position of an error in high half.
  logic [ecc_pkg::HALF_NIB-1:0] pair_hit_lo;  // nibble of a high-half error.
  logic [ecc_pkg::HALF_NIB-1:0] pair_hit_hi;  // nibble of a low-half error.
  ecc_pkg::data_t               flip_mask;

  assign syn_lo = ecc.syndrome[ecc_pkg::SYN_HALF-1:0];
  assign syn_hi = ecc.syndrome[ecc_pkg::CHECK_W-1:ecc_pkg::SYN_HALF];

  assign lo_onehot = $onehot(syn_lo);
  assign hi_onehot = $onehot(syn_hi);

  assign pos_hit_lo = syn_lo & {ecc_pkg::NIBBLE_W{lo_onehot}};
  assign pos_hit_hi = syn_hi & {ecc_pkg::NIBBLE_W{hi_onehot}};

  // match each half against the pair table.
  always_comb begin
    for (int n = 0; n < ecc_pkg::HALF_NIB; n++) begin
      pair_hit_hi[n] = (syn_hi == ecc_pkg::PAIR_PAT[n]);
      pair_hit_lo[n] = (syn_lo == ecc_pkg::PAIR_PAT[n]);
    end
  end

  // one mask bit per data bit, at most one can be set.
  always_comb begin
    flip_mask = '0;
    for (int n = 0; n < ecc_pkg::HALF_NIB; n++) begin
      for (int p = 0; p < ecc_pkg::NIBBLE_W; p++) begin
        flip_mask[n*ecc_pkg::NIBBLE_W + p] = pos_hit_lo[p] & pair_hit_hi[n];
        flip_mask[ecc_pkg::HALF_W + n*ecc_pkg::NIBBLE_W + p] =
          pos_hit_hi[p] & pair_hit_lo[n];
      end
    end
  end

  assign ecc.corrected = ecc.data ^ flip_mask;

  // check-bit errors and multi-bit errors end up here.
  assign ecc.status.located   = |flip_mask;
  assign ecc.status.unlocated = (|ecc.syndrome) & ~(|flip_mask);

endmodule

`default_nettype wire

//--- logic/sec_apb_top.sv
/*
  sec_apb_top
  single-error-correcting decoder as an apb peripheral. the register
  block feeds the syndrome trees and the locator over ecc_if, and the
  decoder results are read back through the same block.
*/
`timescale 1ns/1ps
`default_nettype none

module sec_apb_top (
  input  logic                           pclk,
  input  logic                           rst_n,
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  apb_pkg::reg_addr_t             paddr,
  input  logic [apb_pkg::APB_DATA_W-1:0] pwdata,
  output logic [apb_pkg::APB_DATA_W-1:0] prdata,
  output logic                           pready,
  output logic                           pslverr
);

  ecc_if u_ecc ();  // codeword and decoder results.

  sec_regs u_sec_regs (
    .pclk    (pclk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .ecc     (u_ecc.regs)
  );

  // combinational from here on.
  syndrome_gen u_syndrome_gen (
    .ecc (u_ecc.syn)
  );

  error_locator u_error_locator (
    .ecc (u_ecc.loc)
  );

endmodule

`default_nettype wire

//--- tests/sec_tb.sv
/*
  sec_tb
  testbench of the sec apb peripheral. drives apb accesses on the falling
  edge, replays file vectors, injects random single-bit data errors and
  probes the bus error responses. expected values follow the check rule.
*/
`timescale 1ns/1ps
`default_nettype none

module sec_tb;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 8;
  localparam int RAND_ITERS   = 64;
  localparam int MAX_VECTORS  = 32;  // upper bound on file vectors.
  localparam int N_ACCESSES   = 4 + 4*MAX_VECTORS + 4*RAND_ITERS + 8 + 10;
  localparam int CYCLE_LIMIT  = 4*N_ACCESSES + 50;

  logic                           pclk;
  logic                           rst_n;
  logic                           psel;
  logic                           penable;
  logic                           pwrite;
  apb_pkg::reg_addr_t             paddr;
  logic [apb_pkg::APB_DATA_W-1:0] pwdata;
  logic [apb_pkg::APB_DATA_W-1:0] prdata;
  logic                           pready;
  logic                           pslverr;

  int value_errors;
  int other_errors;
  int seed;
  int cycles;

  sec_apb_top u_sec_apb_top (
    .pclk    (pclk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always #(CLK_PERIOD/2) pclk = ~pclk;

  // syndrome column of data bit i.
  function automatic ecc_pkg::syndrome_t column_of(input int i);
    int n;
    int p;
    ecc_pkg::syndrome_t col;
    n   = i / 4;
    p   = i % 4;
    col = '0;
    if (i < 16) begin
      col[p] = 1'b1;
      col[(n < 2) ? 4 : 5] = 1'b1;       // nibbles 0,1 hit 4, nibbles 2,3 hit 5.
      col[(n % 2 == 0) ? 6 : 7] = 1'b1;  // even nibbles hit 6, odd hit 7.
    end else begin
      col[4 + p] = 1'b1;
      col[(n < 6) ? 0 : 1] = 1'b1;
      col[(n % 2 == 0) ? 2 : 3] = 1'b1;
    end
    return col;
  endfunction

  // check bits that give a zero syndrome for d.
  function automatic ecc_pkg::check_t encode_check(input ecc_pkg::data_t d);
    ecc_pkg::check_t chk;
    chk = '0;
    for (int i = 0; i < ecc_pkg::DATA_W; i++) begin
      if (d[i]) begin
        chk = chk ^ column_of(i);
      end
    end
    return chk;
  endfunction

  task automatic check_data(input string name, input ecc_pkg::data_t exp,
                            input ecc_pkg::data_t act);
    if (act !== exp) begin
      $display("ERROR time=%0t %s expected=%h actual=%h", $time, name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_syndrome(input string name, input ecc_pkg::syndrome_t exp,
                                input ecc_pkg::syndrome_t act);
    if (act !== exp) begin
      $display("ERROR time=%0t %s expected=%h actual=%h", $time, name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_status(input string name, input ecc_pkg::ecc_status_t exp,
                              input ecc_pkg::ecc_status_t act);
    if (act !== exp) begin
      $display("ERROR time=%0t %s expected=%b actual=%b", $time, name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR time=%0t %s expected=%b actual=%b", $time, name, exp, act);
      value_errors++;
    end
  endtask

  // setup on one falling edge, access on the next, sample mid low phase.
  task automatic apb_write(input apb_pkg::reg_addr_t addr,
                           input logic [apb_pkg::APB_DATA_W-1:0] data, output logic err);
    @(negedge pclk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge pclk);
    penable = 1'b1;
    #(CLK_PERIOD/4);
    check_err("pready in write access phase", 1'b1, pready);
    err = pslverr;
  endtask

  task automatic apb_read(input apb_pkg::reg_addr_t addr,
                          output logic [apb_pkg::APB_DATA_W-1:0] data, output logic err);
    @(negedge pclk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    pwdata  = '0;
    @(negedge pclk);
    penable = 1'b1;
    #(CLK_PERIOD/4);
    check_err("pready in read access phase", 1'b1, pready);
    data = prdata;
    err  = pslverr;
  endtask

  task automatic bus_idle();
    @(negedge pclk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  // load a codeword, then read back the corrected word and the status.
  task automatic decode_vector(input ecc_pkg::data_t data, input ecc_pkg::check_t check,
                               input logic en, input ecc_pkg::data_t exp_corr,
                               input ecc_pkg::syndrome_t exp_syn,
                               input ecc_pkg::ecc_status_t exp_status);
    logic [apb_pkg::APB_DATA_W-1:0] rdata;
    logic [apb_pkg::APB_DATA_W-1:0] wdata;
    logic                           err;
    ecc_pkg::ecc_status_t           status;
    apb_write(apb_pkg::REG_DATA, data, err);
    check_err("pslverr on DATA write", 1'b0, err);
    wdata = '0;
    wdata[ecc_pkg::CHECK_W-1:0]  = check;
    wdata[apb_pkg::CHECK_EN_BIT] = en;
    apb_write(apb_pkg::REG_CHECK, wdata, err);
    check_err("pslverr on CHECK write", 1'b0, err);
    apb_read(apb_pkg::REG_CORR, rdata, err);
    check_err("pslverr on CORR read", 1'b0, err);
    check_data("CORR", exp_corr, rdata);
    apb_read(apb_pkg::REG_STATUS, rdata, err);
    check_err("pslverr on STATUS read", 1'b0, err);
    check_syndrome("STATUS syndrome", exp_syn, rdata[ecc_pkg::CHECK_W-1:0]);
    status = rdata[ecc_pkg::CHECK_W +: $bits(ecc_pkg::ecc_status_t)];
    check_status("STATUS flags", exp_status, status);
  endtask

  task automatic reset_readback();
    logic [apb_pkg::APB_DATA_W-1:0] rdata;
    logic                           err;
    for (int k = 0; k < 4; k++) begin
      apb_read(apb_pkg::reg_addr_t'(4*k), rdata, err);  // offsets 0x0 to 0xc.
      check_data("register after reset", '0, rdata);
      check_err("pslverr after reset", 1'b0, err);
    end
  endtask

  task automatic file_vectors();
    int                   fd;
    int                   code;
    int                   n;
    int                   line_no;
    int                   vectors;
    string                line;
    logic [31:0]          f_data;
    logic [31:0]          f_check;
    logic [31:0]          f_en;
    logic [31:0]          f_corr;
    logic [31:0]          f_syn;
    logic [31:0]          f_flags;
    ecc_pkg::ecc_status_t exp_status;
    fd = $fopen("tests/sec_stimulus.txt", "r");
    if (fd == 0) begin
      $display("the stimulus file tests/sec_stimulus.txt could not be opened");
      other_errors++;
      return;
    end
    line_no = 0;
    vectors = 0;
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      line_no++;
      if (code == 0 || line.len() < 2 || line.getc(0) == "#") begin
        continue;  // blank or comment line.
      end
      n = $sscanf(line, "%h %h %h %h %h %h", f_data, f_check, f_en, f_corr, f_syn, f_flags);
      if (n != 6) begin
        $display("stimulus line %0d is malformed, six hex fields were expected", line_no);
        other_errors++;
        continue;
      end
      if (vectors >= MAX_VECTORS) begin
        $display("the stimulus file holds more than %0d vectors", MAX_VECTORS);
        other_errors++;
        break;
      end
      exp_status = f_flags[1:0];
      decode_vector(f_data, f_check[7:0], f_en[0], f_corr, f_syn[7:0], exp_status);
      vectors++;
    end
    $fclose(fd);
    if (vectors == 0) begin
      $display("the stimulus file holds no vectors");
      other_errors++;
    end
  endtask

  task automatic random_single_errors();
    ecc_pkg::data_t       word;
    ecc_pkg::data_t       bad;
    ecc_pkg::check_t      chk;
    int                   bit_idx;
    ecc_pkg::ecc_status_t exp_status;
    exp_status.located   = 1'b1;
    exp_status.unlocated = 1'b0;
    for (int it = 0; it < RAND_ITERS; it++) begin
      word    = $random(seed);
      bit_idx = int'($unsigned($random(seed)) % ecc_pkg::DATA_W);
      chk     = encode_check(word);
      bad     = word ^ (ecc_pkg::data_t'(1) << bit_idx);
      decode_vector(bad, chk, 1'b1, word, column_of(bit_idx), exp_status);
    end
  endtask

  // 0x6 and 0x1 decode to no register in the 4-bit map.
  task automatic bus_error_checks();
    logic [apb_pkg::APB_DATA_W-1:0] rdata;
    logic                           err;
    apb_write(apb_pkg::REG_DATA, 32'h5a5a_1234, err);
    check_err("pslverr on DATA write", 1'b0, err);
    apb_write(apb_pkg::REG_CHECK, 32'h0000_01a5, err);
    check_err("pslverr on CHECK write", 1'b0, err);
    apb_write(apb_pkg::REG_CORR, 32'hffff_ffff, err);
    check_err("pslverr on CORR write", 1'b1, err);
    apb_write(apb_pkg::REG_STATUS, 32'hffff_ffff, err);
    check_err("pslverr on STATUS write", 1'b1, err);
    apb_write(4'h6, 32'hffff_ffff, err);
    check_err("pslverr on unmapped write", 1'b1, err);
    apb_read(4'h1, rdata, err);
    check_err("pslverr on unmapped read", 1'b1, err);
    apb_read(apb_pkg::REG_DATA, rdata, err);
    check_err("pslverr on DATA read", 1'b0, err);
    check_data("DATA after rejected writes", 32'h5a5a_1234, rdata);
    apb_read(apb_pkg::REG_CHECK, rdata, err);
    check_err("pslverr on CHECK read", 1'b0, err);
    check_data("CHECK after rejected writes", 32'h0000_01a5, rdata);
  endtask

  task automatic back_to_back_writes();
    ecc_pkg::data_t                 words [3];
    logic [apb_pkg::APB_DATA_W-1:0] rdata;
    logic                           err;
    words[0] = 32'h0f0f_0001;
    words[1] = 32'h3c3c_0002;
    words[2] = 32'h7777_0003;
    for (int k = 0; k < 3; k++) begin
      apb_write(apb_pkg::REG_DATA, words[k], err);
      check_err("pslverr on DATA write", 1'b0, err);
    end
    apb_read(apb_pkg::REG_DATA, rdata, err);
    check_data("DATA after write burst", words[2], rdata);
    for (int k = 0; k < 3; k++) begin
      apb_write(apb_pkg::REG_DATA, words[k], err);
      apb_read(apb_pkg::REG_DATA, rdata, err);
      check_data("DATA after single write", words[k], rdata);
    end
  endtask

  initial begin : watchdog
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge pclk);
      cycles++;
    end
    $display("timeout, the tests did not finish within %0d cycles", CYCLE_LIMIT);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    pclk         = 1'b0;
    rst_n        = 1'b0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    value_errors = 0;
    other_errors = 0;
    seed         = 32'h4444_9516;
    repeat (RESET_CYCLES) @(negedge pclk);
    rst_n = 1'b1;
    reset_readback();
    file_vectors();
    random_single_errors();
    bus_error_checks();
    back_to_back_writes();
    bus_idle();
    $display("summary: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/sec_stimulus.txt
# data check enable corrected syndrome flags, all hex
# flags: bit 0 located, bit 1 unlocated
00000000 00 1 00000000 00 0
ffffffff 00 1 ffffffff 00 0
00000001 51 1 00000001 00 0
12345678 85 1 12345678 00 0
00000000 ab 0 00000000 00 0
00000003 ff 0 00000003 03 2
00000001 ff 0 00000000 51 1
12345678 85 0 123c5678 85 1
12345678 84 1 12345678 01 2
12345678 c5 1 12345678 40 2
00000000 80 1 00000000 80 2
ffffffff 10 1 ffffffff 10 2
1234567b 85 1 1234567b 03 2
92345679 85 1 92345679 db 2
12344678 85 1 12345678 a1 1
bfffffff 00 1 ffffffff 4a 1

//--- sec_apb_top.f
logic/ecc_pkg.sv
logic/apb_pkg.sv
logic/ecc_if.sv
logic/sec_regs.sv
logic/syndrome_gen.sv
logic/error_locator.sv
logic/sec_apb_top.sv
tests/sec_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the sec testbench with verilator, runs it and scans the log.
# run from the project root.

log=sim.log

rm -f "$log"

verilator --binary --timing --top-module sec_tb -f sec_apb_top.f \
  --Mdir obj_dir -o sec_sim \
  && ./obj_dir/sec_sim > "$log" 2>&1 \
  || { cat "$log" 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat "$log"

[ -s "$log" ] || { echo "simulation log is empty"; exit 1; }

grep -q "TESTS FAILED" "$log" && { echo "simulation failed"; exit 1; } \
  || { echo "simulation passed"; exit 0; }
